//--- common/wfd_pkg.sv
package wfd_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////
	localparam int BUS_DATA_W = 32;
	localparam int BUS_ADDR_W = 8;
	// Upper address bits pick the region
	localparam int REGION_W   = 4;

	//////////////////////////////////////////////////////////////////////
	// Link channels
	//////////////////////////////////////////////////////////////////////
	localparam int N_CHAN     = 4;
	localparam int LINK_W     = 16;
	localparam int FIFO_DEPTH = 16;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);
	// Holds 0 to FIFO_DEPTH inclusive
	localparam int CNT_W      = 5;

	// Front panel LED stretch
	localparam int LED_HOLD   = 64;
	localparam int LED_CNT_W  = $clog2(LED_HOLD + 1);

	typedef logic [LINK_W-1:0]     link_word_t;
	typedef logic [BUS_DATA_W-1:0] bus_word_t;
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

	// Returned for any access outside the map
	localparam bus_word_t UNMAPPED_DATA = 32'h0BAD_ADD0;

	// Address map regions
	typedef enum logic [REGION_W-1:0] {
		REGION_CSR   = 4'd0,
		REGION_CHAN0 = 4'd1,
		REGION_CHAN1 = 4'd2,
		REGION_CHAN2 = 4'd3,
		REGION_CHAN3 = 4'd4,
		REGION_NONE  = 4'hF
	} region_e;

	// Channel register offsets
	typedef enum logic {
		CHAN_DATA   = 1'b0,
		CHAN_STATUS = 1'b1
	} chan_reg_e;

	// Control register offsets
	typedef enum logic {
		CSR_VALUE  = 1'b0,
		CSR_INVERT = 1'b1
	} csr_reg_e;

endpackage

//--- common/wfd_bus_if.sv
`timescale 1ns/1ps

interface wfd_bus_if;
	import wfd_pkg::*;

	// Cycle and strobe stay high until ack
	logic      cyc;
	logic      stb;
	logic      we;
	// Word offset inside the selected region
	logic      offset;
	bus_word_t wdat;
	bus_word_t rdat;
	logic      ack;

	modport master (
		output cyc, stb, we, offset, wdat,
		input  rdat, ack
	);

	modport slave (
		input  cyc, stb, we, offset, wdat,
		output rdat, ack
	);

endinterface

//--- rcv_channel/rcv_fifo.sv
`timescale 1ns/1ps

module rcv_fifo (
	input  logic                    CLK125,
	input  logic                    arst_n_i,
	input  logic                    wr_en_i,
	input  wfd_pkg::link_word_t     wr_data_i,
	input  logic                    rd_en_i,
	output wfd_pkg::link_word_t     rd_data_o,
	output logic [wfd_pkg::CNT_W-1:0] count_o,
	input  logic                    ovf_clr_i,
	output logic                    overflow_o
);
	import wfd_pkg::*;

	link_word_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             ovf_q;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	// Wrap at the last slot so any depth works
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (count_q == CNT_W'(FIFO_DEPTH));
	assign do_wr = wr_en_i & ~full;
	assign do_rd = rd_en_i & (count_q != '0);

	always_ff @(posedge CLK125) begin
		if (do_wr) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			ovf_q    <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_rd) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			// Push and pop together leave the count alone
			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// A lost word beats a clear in the same cycle
			if (wr_en_i && full) begin
				ovf_q <= 1'b1;
			end else if (ovf_clr_i) begin
				ovf_q <= 1'b0;
			end
		end
	end

	// Head word is always on the output
	assign rd_data_o  = mem[rd_ptr_q];
	assign count_o    = count_q;
	assign overflow_o = ovf_q;

endmodule

//--- rcv_channel/rcv_channel.sv
`timescale 1ns/1ps

module rcv_channel (
	input  logic                CLK125,
	input  logic                arst_n_i,
	wfd_bus_if.slave            bus,
	input  wfd_pkg::link_word_t link_data_i,
	input  logic                link_kchar_i,
	output logic                overflow_o
);
	import wfd_pkg::*;

	logic             ack_q;
	logic             access;
	logic             fifo_empty;
	logic             pop;
	logic             ovf_clr;
	chan_reg_e        reg_sel;
	link_word_t       head;
	logic [CNT_W-1:0] count;
	bus_word_t        status;
	bus_word_t        rdat_q;

	assign reg_sel    = chan_reg_e'(bus.offset);
	assign access     = bus.cyc & bus.stb & ~ack_q;
	assign fifo_empty = (count == '0);
	// Pop lands on the same edge that raises ack
	assign pop        = access & ~bus.we & (reg_sel == CHAN_DATA) & ~fifo_empty;
	assign ovf_clr    = access & bus.we & (reg_sel == CHAN_STATUS);

	// Overflow on top, word count at the bottom
	always_comb begin
		status                 = '0;
		status[BUS_DATA_W-1]   = overflow_o;
		status[CNT_W-1:0]      = count;
	end

	// K-flagged words are idles and never stored
	rcv_fifo u_fifo (
		.CLK125     (CLK125),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (~link_kchar_i),
		.wr_data_i  (link_data_i),
		.rd_en_i    (pop),
		.rd_data_o  (head),
		.count_o    (count),
		.ovf_clr_i  (ovf_clr),
		.overflow_o (overflow_o)
	);

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge CLK125) begin
		if (access) begin
			if (reg_sel == CHAN_STATUS) begin
				rdat_q <= status;
			end else if (fifo_empty) begin
				rdat_q <= '0;
			end else begin
				rdat_q <= BUS_DATA_W'(head);
			end
		end
	end

	assign bus.rdat = rdat_q;
	assign bus.ack  = ack_q;

endmodule

//--- design/led_engine.sv
`timescale 1ns/1ps

module led_engine (
	input  logic CLK125,
	input  logic arst_n_i,
	input  logic trig_i,
	output logic led_o
);
	import wfd_pkg::*;

	logic                 trig_q;
	logic                 trig_rise;
	logic [LED_CNT_W-1:0] hold_q;

	assign trig_rise = trig_i & ~trig_q;

	// Retrigger reloads the full hold time
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			trig_q <= 1'b0;
			hold_q <= '0;
		end else begin
			trig_q <= trig_i;
			if (trig_rise) begin
				hold_q <= LED_CNT_W'(LED_HOLD);
			end else if (hold_q != '0) begin
				hold_q <= hold_q - 1'b1;
			end
		end
	end

	assign led_o = (hold_q != '0);

endmodule

//--- design/main_csr.sv
`timescale 1ns/1ps

module main_csr (
	input  logic     CLK125,
	input  logic     arst_n_i,
	wfd_bus_if.slave bus,
	output logic     link_rst_o
);
	import wfd_pkg::*;

	bus_word_t ctrl_q;
	logic      ack_q;
	logic      access;
	csr_reg_e  reg_sel;

	assign reg_sel = csr_reg_e'(bus.offset);
	// First cycle of a selected strobe
	assign access  = bus.cyc & bus.stb & ~ack_q;

	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= access;
			// Writes to the inverted view are dropped
			if (access && bus.we && reg_sel == CSR_VALUE) begin
				ctrl_q <= bus.wdat;
			end
		end
	end

	// Complement view lets the host check every data line
	assign bus.rdat   = (reg_sel == CSR_INVERT) ? ~ctrl_q : ctrl_q;
	assign bus.ack    = ack_q;
	assign link_rst_o = ctrl_q[BUS_DATA_W-1];

endmodule

//--- design/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input  logic               CLK125,
	input  logic               arst_n_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  wfd_pkg::bus_addr_t adr_i,
	input  wfd_pkg::bus_word_t dat_i,
	output wfd_pkg::bus_word_t dat_o,
	output logic               ack_o,
	wfd_bus_if.master          csr_bus,
	wfd_bus_if.master          chan_bus [wfd_pkg::N_CHAN]
);
	import wfd_pkg::*;

	logic              req;
	logic              req_q;
	logic              busy_q;
	region_e           region_q;
	logic              none_ack_q;
	logic              csr_sel;
	logic              none_sel;
	logic [N_CHAN-1:0] chan_sel;
	logic [N_CHAN-1:0] chan_ack;
	bus_word_t         chan_rdat [N_CHAN];

	function automatic region_e decode_region(input bus_addr_t adr);
		case (adr[BUS_ADDR_W-1 -: REGION_W])
			4'd0:    return REGION_CSR;
			4'd1:    return REGION_CHAN0;
			4'd2:    return REGION_CHAN1;
			4'd3:    return REGION_CHAN2;
			4'd4:    return REGION_CHAN3;
			default: return REGION_NONE;
		endcase
	endfunction

	assign req = cyc_i & stb_i;

	// Latch the region on the rise of a request and release on ack or abort
	always_ff @(posedge CLK125 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q      <= 1'b0;
			busy_q     <= 1'b0;
			region_q   <= REGION_NONE;
			none_ack_q <= 1'b0;
		end else begin
			req_q      <= req;
			none_ack_q <= none_sel & req & ~none_ack_q;
			if (!busy_q && req && !req_q) begin
				busy_q   <= 1'b1;
				region_q <= decode_region(adr_i);
			end else if (ack_o || !req) begin
				busy_q <= 1'b0;
			end
		end
	end

	assign csr_sel  = busy_q && (region_q == REGION_CSR);
	assign none_sel = busy_q && (region_q == REGION_NONE);

	assign csr_bus.cyc    = csr_sel & cyc_i;
	assign csr_bus.stb    = csr_sel & stb_i;
	assign csr_bus.we     = csr_sel & we_i;
	assign csr_bus.offset = adr_i[0];
	assign csr_bus.wdat   = dat_i;

	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		assign chan_sel[i]        = busy_q && (region_q == region_e'(REGION_CHAN0 + i));
		assign chan_bus[i].cyc    = chan_sel[i] & cyc_i;
		assign chan_bus[i].stb    = chan_sel[i] & stb_i;
		assign chan_bus[i].we     = chan_sel[i] & we_i;
		assign chan_bus[i].offset = adr_i[0];
		assign chan_bus[i].wdat   = dat_i;
		assign chan_ack[i]        = chan_bus[i].ack;
		assign chan_rdat[i]       = chan_bus[i].rdat;
	end

	// Unmapped answers are the default of the return path
	always_comb begin
		dat_o = UNMAPPED_DATA;
		ack_o = none_ack_q;
		if (csr_sel) begin
			dat_o = csr_bus.rdat;
			ack_o = csr_bus.ack;
		end
		for (int i = 0; i < N_CHAN; i++) begin
			if (chan_sel[i]) begin
				dat_o = chan_rdat[i];
				ack_o = chan_ack[i];
			end
		end
	end

endmodule

//--- design/wfd_top.sv
`timescale 1ns/1ps

module wfd_top (
	input  logic                        CLK125,
	input  logic                        arst_n_i,
	// Host register bus
	input  logic                        bus_cyc_i,
	input  logic                        bus_stb_i,
	input  logic                        bus_we_i,
	input  wfd_pkg::bus_addr_t          bus_adr_i,
	input  wfd_pkg::bus_word_t          bus_dat_i,
	output wfd_pkg::bus_word_t          bus_dat_o,
	output logic                        bus_ack_o,
	// Link word streams from the channel FPGAs
	input  wfd_pkg::link_word_t         link_data_i [wfd_pkg::N_CHAN],
	input  logic [wfd_pkg::N_CHAN-1:0]  link_kchar_i,
	// Front panel and channel reset
	output logic [wfd_pkg::N_CHAN-1:0]  led_o,
	output logic                        link_rst_o
);
	import wfd_pkg::*;

	logic [N_CHAN-1:0] chan_ovf;

	wfd_bus_if csr_bus ();
	wfd_bus_if chan_bus [N_CHAN] ();

	//////////////////////////////////////////////////////////////////////
	// Address decoder and control register
	//////////////////////////////////////////////////////////////////////
	bus_decoder u_decoder (
		.CLK125   (CLK125),
		.arst_n_i (arst_n_i),
		.cyc_i    (bus_cyc_i),
		.stb_i    (bus_stb_i),
		.we_i     (bus_we_i),
		.adr_i    (bus_adr_i),
		.dat_i    (bus_dat_i),
		.dat_o    (bus_dat_o),
		.ack_o    (bus_ack_o),
		.csr_bus  (csr_bus),
		.chan_bus (chan_bus)
	);

	main_csr u_csr (
		.CLK125     (CLK125),
		.arst_n_i   (arst_n_i),
		.bus        (csr_bus),
		.link_rst_o (link_rst_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive channels with their overflow LEDs
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		rcv_channel u_chan (
			.CLK125       (CLK125),
			.arst_n_i     (arst_n_i),
			.bus          (chan_bus[i]),
			.link_data_i  (link_data_i[i]),
			.link_kchar_i (link_kchar_i[i]),
			.overflow_o   (chan_ovf[i])
		);

		led_engine u_led (
			.CLK125   (CLK125),
			.arst_n_i (arst_n_i),
			.trig_i   (chan_ovf[i]),
			.led_o    (led_o[i])
		);
	end

endmodule

//--- dv/tb_wfd_tasks.svh
`ifndef TB_WFD_TASKS_SVH
`define TB_WFD_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Register bus access
//////////////////////////////////////////////////////////////////////
function automatic bus_addr_t reg_addr(input int region, input logic off);
	bus_addr_t a;
	a = '0;
	a[BUS_ADDR_W-1 -: REGION_W] = REGION_W'(region);
	a[0] = off;
	return a;
endfunction

// Strobe held until ack and dropped for at least one cycle after it
task automatic bus_access(input logic we, input bus_addr_t adr, input bus_word_t wdat,
		output bus_word_t rdat);
	@(negedge CLK125);
	bus_cyc_i = 1'b1;
	bus_stb_i = 1'b1;
	bus_we_i  = we;
	bus_adr_i = adr;
	bus_dat_i = wdat;
	ack_lat   = 0;
	do begin
		@(negedge CLK125);
		ack_lat++;
	end while (!bus_ack_o && ack_lat < ACK_TIMEOUT);
	if (!bus_ack_o) begin
		$display("Bus access to address 0x%02h got no ack within %0d cycles", adr, ACK_TIMEOUT);
		end_with_failure();
	end
	rdat      = bus_dat_o;
	bus_cyc_i = 1'b0;
	bus_stb_i = 1'b0;
	bus_we_i  = 1'b0;
endtask

task automatic bus_write(input bus_addr_t adr, input bus_word_t data);
	bus_word_t unused;
	bus_access(1'b1, adr, data, unused);
endtask

task automatic bus_read(input bus_addr_t adr, output bus_word_t data);
	bus_access(1'b0, adr, '0, data);
endtask

//////////////////////////////////////////////////////////////////////
// Link streams and the channel model
//////////////////////////////////////////////////////////////////////
// Sends words_left valid words per channel with random idles between
task automatic drive_links();
	logic busy;
	do begin
		@(negedge CLK125);
		busy = 1'b0;
		for (int c = 0; c < N_CHAN; c++) begin
			link_data_i[c]  = link_word_t'(rand_bits(LINK_W));
			link_kchar_i[c] = 1'b1;
			if (words_left[c] > 0 && rand_bits(1) == 32'd0) begin
				link_kchar_i[c] = 1'b0;
				words_left[c]--;
				if (model_q[c].size() < FIFO_DEPTH) begin
					model_q[c].push_back(link_data_i[c]);
				end else begin
					model_ovf[c] = 1'b1;
				end
			end
			if (words_left[c] > 0) begin
				busy = 1'b1;
			end
		end
	end while (busy);
	@(negedge CLK125);
	link_kchar_i = '1;
endtask

task automatic check_status(input int ch);
	bus_word_t rd;
	bus_word_t exp;
	bus_read(reg_addr(ch + 1, CHAN_STATUS), rd);
	exp = bus_word_t'(model_q[ch].size());
	exp[BUS_DATA_W-1] = model_ovf[ch];
	check($sformatf("chan%0d status", ch), exp, rd);
endtask

// Pops every predicted word and reads the empty FIFO once more
task automatic drain_channel(input int ch);
	bus_word_t  rd;
	link_word_t w;
	while (model_q[ch].size() > 0) begin
		w = model_q[ch].pop_front();
		bus_read(reg_addr(ch + 1, CHAN_DATA), rd);
		check($sformatf("chan%0d data", ch), bus_word_t'(w), rd);
	end
	bus_read(reg_addr(ch + 1, CHAN_DATA), rd);
	check($sformatf("chan%0d empty data", ch), '0, rd);
	check_status(ch);
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////
task automatic test_csr();
	bus_word_t v;
	bus_word_t rd;
	bus_read(reg_addr(REGION_CSR, CSR_VALUE), rd);
	check("csr value after reset", '0, rd);
	check("link_rst_o after reset", '0, link_rst_o);
	// First pass raises the link reset and the second drops it again
	for (int k = 0; k < 2; k++) begin
		v = rand_bits(32);
		v[31] = (k == 0);
		bus_write(reg_addr(REGION_CSR, CSR_VALUE), v);
		bus_read(reg_addr(REGION_CSR, CSR_VALUE), rd);
		check("csr value", v, rd);
		bus_read(reg_addr(REGION_CSR, CSR_INVERT), rd);
		check("csr invert", ~v, rd);
		check("link_rst_o", v[31], link_rst_o);
	end
endtask

task automatic test_data_path();
	for (int c = 0; c < N_CHAN; c++) begin
		words_left[c] = 10;
	end
	drive_links();
	for (int c = 0; c < N_CHAN; c++) begin
		check_status(c);
		drain_channel(c);
	end
endtask

task automatic test_independence();
	words_left = '{3, 7, 1, 12};
	drive_links();
	for (int c = 0; c < N_CHAN; c++) begin
		check_status(c);
	end
	for (int c = 0; c < N_CHAN; c++) begin
		drain_channel(c);
	end
endtask

task automatic test_overflow();
	int                n;
	int                ch;
	logic [N_CHAN-1:0] others;
	ch     = 2;
	others = ~(N_CHAN'(1) << ch);
	words_left[ch] = FIFO_DEPTH + 3;
	drive_links();
	n = 0;
	while (!led_o[ch] && n < LED_RISE_TIMEOUT) begin
		@(negedge CLK125);
		n++;
	end
	if (!led_o[ch]) begin
		$display("Overflow LED of channel %0d never lit", ch);
		end_with_failure();
	end
	n = 0;
	while (led_o[ch] && n < LED_HOLD + 5) begin
		check("led_o of idle channels", '0, led_o & others);
		@(negedge CLK125);
		n++;
	end
	if (led_o[ch]) begin
		$display("Overflow LED of channel %0d stayed on too long", ch);
		end_with_failure();
	end
	check_status(ch);
	drain_channel(ch);
	bus_write(reg_addr(ch + 1, CHAN_STATUS), '0);
	model_ovf[ch] = 1'b0;
	check_status(ch);
endtask

task automatic test_unmapped();
	bus_word_t v;
	bus_word_t rd;
	v = rand_bits(32);
	v[31] = 1'b0;
	bus_write(reg_addr(REGION_CSR, CSR_VALUE), v);
	// Channel 0 overflow makes a stray status write visible
	words_left = '{FIFO_DEPTH + 1, 3, 4, 5};
	drive_links();
	bus_read(reg_addr(5, 1'b0), rd);
	check("unmapped read", UNMAPPED_DATA, rd);
	bus_read(reg_addr(15, 1'b1), rd);
	check("unmapped read", UNMAPPED_DATA, rd);
	bus_write(reg_addr(5, 1'b0), ~v);
	bus_write(reg_addr(9, 1'b1), rand_bits(32));
	bus_read(reg_addr(REGION_CSR, CSR_VALUE), rd);
	check("csr after unmapped write", v, rd);
	for (int c = 0; c < N_CHAN; c++) begin
		check_status(c);
		drain_channel(c);
	end
	bus_write(reg_addr(REGION_CHAN0, CHAN_STATUS), '0);
	model_ovf[0] = 1'b0;
	check_status(0);
	bus_write(reg_addr(REGION_CSR, CSR_VALUE), '0);
endtask

// Ack seen on the second falling edge and gone on the third
task automatic test_ack_timing();
	bus_word_t rd;
	bus_addr_t targets [3];
	targets[0] = reg_addr(REGION_CSR, CSR_VALUE);
	targets[1] = reg_addr(REGION_CHAN1, CHAN_STATUS);
	targets[2] = reg_addr(12, 1'b0);
	for (int t = 0; t < 3; t++) begin
		bus_read(targets[t], rd);
		check("bus_ack_o latency", 32'd2, ack_lat);
		@(negedge CLK125);
		check("bus_ack_o width", '0, bus_ack_o);
	end
endtask

`endif

//--- dv/tb_wfd_top.sv
`timescale 1ns/1ps

module tb_wfd_top;
	import wfd_pkg::*;

	localparam int ACK_TIMEOUT = 20;
	localparam int LED_RISE_TIMEOUT = 8;
	localparam logic [31:0] LFSR_SEED = 32'he4ab_e302;

	logic              CLK125;
	logic              arst_n_i;
	logic              bus_cyc_i;
	logic              bus_stb_i;
	logic              bus_we_i;
	bus_addr_t         bus_adr_i;
	bus_word_t         bus_dat_i;
	bus_word_t         bus_dat_o;
	logic              bus_ack_o;
	link_word_t        link_data_i [N_CHAN];
	logic [N_CHAN-1:0] link_kchar_i;
	logic [N_CHAN-1:0] led_o;
	logic              link_rst_o;

	logic [31:0]       lfsr_q;
	int                ack_lat;
	int                error_count;
	int                words_left [N_CHAN];
	// Predicted FIFO contents and sticky overflow per channel
	link_word_t        model_q [N_CHAN][$];
	logic [N_CHAN-1:0] model_ovf;

	wfd_top u_dut (
		.CLK125       (CLK125),
		.arst_n_i     (arst_n_i),
		.bus_cyc_i    (bus_cyc_i),
		.bus_stb_i    (bus_stb_i),
		.bus_we_i     (bus_we_i),
		.bus_adr_i    (bus_adr_i),
		.bus_dat_i    (bus_dat_i),
		.bus_dat_o    (bus_dat_o),
		.bus_ack_o    (bus_ack_o),
		.link_data_i  (link_data_i),
		.link_kchar_i (link_kchar_i),
		.led_o        (led_o),
		.link_rst_o   (link_rst_o)
	);

	// 50 MHz simulation clock
	always #10 CLK125 = ~CLK125;

	//////////////////////////////////////////////////////////////////////
	// Random source and result checking
	//////////////////////////////////////////////////////////////////////
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	task automatic end_with_failure();
		error_count++;
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
			end_with_failure();
		end
	endtask

	`include "tb_wfd_tasks.svh"

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		CLK125       = 1'b0;
		arst_n_i     = 1'b0;
		bus_cyc_i    = 1'b0;
		bus_stb_i    = 1'b0;
		bus_we_i     = 1'b0;
		bus_adr_i    = '0;
		bus_dat_i    = '0;
		link_kchar_i = '1;
		for (int c = 0; c < N_CHAN; c++) begin
			link_data_i[c] = '0;
			words_left[c]  = 0;
		end
		model_ovf   = '0;
		lfsr_q      = LFSR_SEED;
		ack_lat     = 0;
		error_count = 0;

		repeat (16) @(negedge CLK125);
		arst_n_i = 1'b1;
		@(negedge CLK125);

		test_csr();
		test_data_path();
		test_independence();
		test_overflow();
		test_unmapped();
		test_ack_timing();

		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
common/wfd_pkg.sv
common/wfd_bus_if.sv
rcv_channel/rcv_fifo.sv
rcv_channel/rcv_channel.sv
design/led_engine.sv
design/main_csr.sv
design/bus_decoder.sv
design/wfd_top.sv
dv/tb_wfd_top.sv

//--- Bender.yml
package:
  name: wfd_readout

sources:
  - common/wfd_pkg.sv
  - common/wfd_bus_if.sv
  - rcv_channel/rcv_fifo.sv
  - rcv_channel/rcv_channel.sv
  - design/led_engine.sv
  - design/main_csr.sv
  - design/bus_decoder.sv
  - design/wfd_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_wfd_top.sv
